/* verilog/axi3_pkg.sv */
package axi3_pkg;

    // ----------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------
    localparam int ADDR_WID     = 32;
    localparam int DATA_WID     = 64;
    // Byte offset within a 64-bit word
    localparam int BYTE_SEL_WID = 3;

    // ----------------------------------------------------------
    // RAM geometry
    // ----------------------------------------------------------
    localparam int RAM_WORDS      = 256;
    localparam int RAM_IDX_WID    = 8;
    localparam int RAM_RD_LATENCY = 3;

    // Address bits above the mapped range, all zero for a hit
    localparam int RAM_MAP_LSB = BYTE_SEL_WID + RAM_IDX_WID;

    localparam logic [RAM_IDX_WID-1:0] RAM_LAST_IDX = RAM_IDX_WID'(RAM_WORDS - 1);

    // Wait states between read address and data, minus one
    localparam int                    RD_LAT_WID  = $clog2(RAM_RD_LATENCY);
    localparam logic [RD_LAT_WID-1:0] RD_LAT_LAST = RD_LAT_WID'(RAM_RD_LATENCY - 2);

    // ----------------------------------------------------------
    // Adapter timeouts
    // ----------------------------------------------------------
    localparam int WR_TIMEOUT = 64;
    localparam int RD_TIMEOUT = 64;

    localparam int                      WR_TIMER_WID  = $clog2(WR_TIMEOUT);
    localparam logic [WR_TIMER_WID-1:0] WR_TIMER_LAST = WR_TIMER_WID'(WR_TIMEOUT - 1);
    localparam int                      RD_TIMER_WID  = $clog2(RD_TIMEOUT);
    localparam logic [RD_TIMER_WID-1:0] RD_TIMER_LAST = RD_TIMER_WID'(RD_TIMEOUT - 1);

    // RAM controller states
    typedef enum logic [2:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_WR_RESP,
        ST_RD_WAIT,
        ST_RD_RESP
    } ram_state_t;

endpackage : axi3_pkg

/* verilog/mem_wr_intf.sv */
interface mem_wr_intf;

    logic                          req;
    logic                          rdy;
    logic                          ack;
    logic [axi3_pkg::ADDR_WID-1:0] addr;
    logic [axi3_pkg::DATA_WID-1:0] data;

    // Request source
    modport controller (
        output req, addr, data,
        input  rdy, ack
    );

    // Request sink
    modport peripheral (
        input  req, addr, data,
        output rdy, ack
    );

endinterface : mem_wr_intf

/* verilog/mem_rd_intf.sv */
interface mem_rd_intf;

    logic                          req;
    logic                          rdy;
    logic                          ack;
    logic [axi3_pkg::ADDR_WID-1:0] addr;
    // Valid in the ack cycle
    logic [axi3_pkg::DATA_WID-1:0] data;

    modport controller (
        output req, addr,
        input  rdy, ack, data
    );

    modport peripheral (
        input  req, addr,
        output rdy, ack, data
    );

endinterface : mem_rd_intf

/* verilog/axi3_intf.sv */
interface axi3_intf;

    // Write address
    logic                          awvalid;
    logic                          awready;
    logic [axi3_pkg::ADDR_WID-1:0] awaddr;

    // Write data, single full-width beat
    logic                          wvalid;
    logic                          wready;
    logic [axi3_pkg::DATA_WID-1:0] wdata;

    // Write response
    logic                          bvalid;
    logic                          bready;

    // Read address
    logic                          arvalid;
    logic                          arready;
    logic [axi3_pkg::ADDR_WID-1:0] araddr;

    // Read data
    logic                          rvalid;
    logic                          rready;
    logic [axi3_pkg::DATA_WID-1:0] rdata;

    modport controller (
        output awvalid, awaddr, wvalid, wdata, bready,
        output arvalid, araddr, rready,
        input  awready, wready, bvalid, arready, rvalid, rdata
    );

    modport peripheral (
        input  awvalid, awaddr, wvalid, wdata, bready,
        input  arvalid, araddr, rready,
        output awready, wready, bvalid, arready, rvalid, rdata
    );

endinterface : axi3_intf

/* verilog/axi3_mem_adapter.sv */
module axi3_mem_adapter (
    input  logic           clk,
    input  logic           srst,

    mem_wr_intf.peripheral mem_wr_if,
    mem_rd_intf.peripheral mem_rd_if,

    axi3_intf.controller   axi3_if
);

    logic                                wr_accept;
    logic                                wr_pending;
    logic                                wr_timeout;
    logic [axi3_pkg::WR_TIMER_WID-1:0]   wr_timer;

    logic                                rd_accept;
    logic                                rd_pending;
    logic                                rd_timeout;
    logic [axi3_pkg::RD_TIMER_WID-1:0]   rd_timer;

    // ----------------------------------------------------------
    // Write channel
    // ----------------------------------------------------------
    assign wr_accept     = mem_wr_if.req && mem_wr_if.rdy;
    assign mem_wr_if.rdy = !wr_pending;
    assign wr_timeout    = wr_pending && (wr_timer == axi3_pkg::WR_TIMER_LAST);

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_pending        <= 1'b0;
            wr_timer          <= '0;
            axi3_if.awvalid   <= 1'b0;
            axi3_if.wvalid    <= 1'b0;
            axi3_if.bready    <= 1'b0;
            mem_wr_if.ack     <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_pending <= 1'b1;
            end else if (mem_wr_if.ack) begin
                wr_pending <= 1'b0;
            end

            // Counts only while a write is outstanding
            if (wr_pending) begin
                wr_timer <= wr_timer + 1'b1;
            end else begin
                wr_timer <= '0;
            end

            // Address and data issued together
            if (wr_accept) begin
                axi3_if.awvalid <= 1'b1;
                axi3_if.wvalid  <= 1'b1;
            end else begin
                if (axi3_if.awready || wr_timeout) begin
                    axi3_if.awvalid <= 1'b0;
                end
                if (axi3_if.wready || wr_timeout) begin
                    axi3_if.wvalid <= 1'b0;
                end
            end

            // Idle bready follows bvalid so a late response is drained
            if (wr_accept) begin
                axi3_if.bready <= 1'b1;
            end else if (wr_pending) begin
                if (axi3_if.bvalid || wr_timeout) begin
                    axi3_if.bready <= 1'b0;
                end
            end else begin
                axi3_if.bready <= axi3_if.bvalid;
            end

            mem_wr_if.ack <= wr_pending && !mem_wr_if.ack &&
                             (wr_timeout || (axi3_if.bvalid && axi3_if.bready));
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            axi3_if.awaddr <= mem_wr_if.addr;
            axi3_if.wdata  <= mem_wr_if.data;
        end
    end

    // ----------------------------------------------------------
    // Read channel
    // ----------------------------------------------------------
    assign rd_accept     = mem_rd_if.req && mem_rd_if.rdy;
    assign mem_rd_if.rdy = !rd_pending;
    assign rd_timeout    = rd_pending && (rd_timer == axi3_pkg::RD_TIMER_LAST);

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_pending      <= 1'b0;
            rd_timer        <= '0;
            axi3_if.arvalid <= 1'b0;
            axi3_if.rready  <= 1'b0;
            mem_rd_if.ack   <= 1'b0;
        end else begin
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (mem_rd_if.ack) begin
                rd_pending <= 1'b0;
            end

            if (rd_pending) begin
                rd_timer <= rd_timer + 1'b1;
            end else begin
                rd_timer <= '0;
            end

            if (rd_accept) begin
                axi3_if.arvalid <= 1'b1;
            end else if (axi3_if.arready || rd_timeout) begin
                axi3_if.arvalid <= 1'b0;
            end

            if (rd_accept) begin
                axi3_if.rready <= 1'b1;
            end else if (rd_pending) begin
                if (axi3_if.rvalid || rd_timeout) begin
                    axi3_if.rready <= 1'b0;
                end
            end else begin
                axi3_if.rready <= axi3_if.rvalid;
            end

            mem_rd_if.ack <= rd_pending && !mem_rd_if.ack &&
                             (rd_timeout || (axi3_if.rvalid && axi3_if.rready));
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            axi3_if.araddr <= mem_rd_if.addr;
        end
        // Real data wins over a timeout in the same cycle
        if (rd_pending && axi3_if.rvalid && axi3_if.rready) begin
            mem_rd_if.data <= axi3_if.rdata;
        end else if (rd_timeout) begin
            mem_rd_if.data <= '0;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_wr_ack_pending : assert property (@(posedge clk) disable iff (srst)
        mem_wr_if.ack |-> wr_pending);

    a_rd_ack_pending : assert property (@(posedge clk) disable iff (srst)
        mem_rd_if.ack |-> rd_pending);

    // Holds only if the slave raises awready and wready together
    a_aw_w_paired : assert property (@(posedge clk) disable iff (srst)
        axi3_if.awvalid == axi3_if.wvalid);

endmodule : axi3_mem_adapter

/* verilog/axi3_ram.sv */
module axi3_ram (
    input  logic         clk,
    input  logic         srst,
    output logic         init_done,
    axi3_intf.peripheral axi3_if
);

    axi3_pkg::ram_state_t                state;

    logic [axi3_pkg::DATA_WID-1:0]       mem [axi3_pkg::RAM_WORDS];

    logic [axi3_pkg::RAM_IDX_WID-1:0]    clr_idx;
    logic [axi3_pkg::RAM_IDX_WID-1:0]    wr_idx;
    logic [axi3_pkg::RAM_IDX_WID-1:0]    ar_idx;
    logic [axi3_pkg::RAM_IDX_WID-1:0]    rd_idx;
    logic [axi3_pkg::RD_LAT_WID-1:0]     lat_cnt;

    logic                                wr_mapped;
    logic                                rd_mapped;
    logic                                wr_go;
    logic                                rd_go;
    logic                                rd_fetch;

    // ----------------------------------------------------------
    // Address decode and channel arbitration
    // ----------------------------------------------------------
    assign wr_idx    = axi3_if.awaddr[axi3_pkg::BYTE_SEL_WID +: axi3_pkg::RAM_IDX_WID];
    assign ar_idx    = axi3_if.araddr[axi3_pkg::BYTE_SEL_WID +: axi3_pkg::RAM_IDX_WID];
    assign wr_mapped = (axi3_if.awaddr[axi3_pkg::ADDR_WID-1:axi3_pkg::RAM_MAP_LSB] == '0);
    assign rd_mapped = (axi3_if.araddr[axi3_pkg::ADDR_WID-1:axi3_pkg::RAM_MAP_LSB] == '0);

    // Write wins when both are valid
    assign wr_go = (state == axi3_pkg::ST_IDLE) && axi3_if.awvalid && axi3_if.wvalid &&
                   wr_mapped;
    assign rd_go = (state == axi3_pkg::ST_IDLE) && axi3_if.arvalid && rd_mapped && !wr_go;

    assign axi3_if.awready = wr_go;
    assign axi3_if.wready  = wr_go;
    assign axi3_if.arready = rd_go;
    assign axi3_if.bvalid  = (state == axi3_pkg::ST_WR_RESP);
    assign axi3_if.rvalid  = (state == axi3_pkg::ST_RD_RESP);

    assign init_done = (state != axi3_pkg::ST_CLEAR);
    assign rd_fetch  = (state == axi3_pkg::ST_RD_WAIT) && (lat_cnt == axi3_pkg::RD_LAT_LAST);

    // ----------------------------------------------------------
    // Controller FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state   <= axi3_pkg::ST_CLEAR;
            clr_idx <= '0;
            lat_cnt <= '0;
        end else begin
            case (state)
                axi3_pkg::ST_CLEAR: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == axi3_pkg::RAM_LAST_IDX) begin
                        state <= axi3_pkg::ST_IDLE;
                    end
                end
                axi3_pkg::ST_IDLE: begin
                    if (wr_go) begin
                        state <= axi3_pkg::ST_WR_RESP;
                    end else if (rd_go) begin
                        state   <= axi3_pkg::ST_RD_WAIT;
                        lat_cnt <= '0;
                    end
                end
                axi3_pkg::ST_WR_RESP: begin
                    if (axi3_if.bready) begin
                        state <= axi3_pkg::ST_IDLE;
                    end
                end
                axi3_pkg::ST_RD_WAIT: begin
                    if (rd_fetch) begin
                        state <= axi3_pkg::ST_RD_RESP;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                axi3_pkg::ST_RD_RESP: begin
                    if (axi3_if.rready) begin
                        state <= axi3_pkg::ST_IDLE;
                    end
                end
                default: state <= axi3_pkg::ST_CLEAR;
            endcase
        end
    end

    // Storage and read path
    always_ff @(posedge clk) begin
        if (state == axi3_pkg::ST_CLEAR) begin
            mem[clr_idx] <= '0;
        end else if (wr_go) begin
            mem[wr_idx] <= axi3_if.wdata;
        end
        if (rd_go) begin
            rd_idx <= ar_idx;
        end
        if (rd_fetch) begin
            axi3_if.rdata <= mem[rd_idx];
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_rvalid_hold : assert property (@(posedge clk) disable iff (srst)
        axi3_if.rvalid && !axi3_if.rready |=> axi3_if.rvalid && $stable(axi3_if.rdata));

    a_no_ready_in_clear : assert property (@(posedge clk) disable iff (srst)
        !init_done |-> !(axi3_if.awready || axi3_if.wready || axi3_if.arready));

endmodule : axi3_ram

/* verilog/axi3_mem_sys.sv */
module axi3_mem_sys (
    input  logic                          clk,
    input  logic                          srst,

    output logic                          init_done,

    // Write request
    input  logic                          wr_req,
    input  logic [axi3_pkg::ADDR_WID-1:0] wr_addr,
    input  logic [axi3_pkg::DATA_WID-1:0] wr_data,
    output logic                          wr_rdy,
    output logic                          wr_ack,

    // Read request
    input  logic                          rd_req,
    input  logic [axi3_pkg::ADDR_WID-1:0] rd_addr,
    output logic                          rd_rdy,
    output logic                          rd_ack,
    output logic [axi3_pkg::DATA_WID-1:0] rd_data
);

    mem_wr_intf mem_wr_if ();
    mem_rd_intf mem_rd_if ();
    axi3_intf   axi3_if ();

    // Plain ports onto the request interfaces
    assign mem_wr_if.req  = wr_req;
    assign mem_wr_if.addr = wr_addr;
    assign mem_wr_if.data = wr_data;
    assign wr_rdy         = mem_wr_if.rdy;
    assign wr_ack         = mem_wr_if.ack;

    assign mem_rd_if.req  = rd_req;
    assign mem_rd_if.addr = rd_addr;
    assign rd_rdy         = mem_rd_if.rdy;
    assign rd_ack         = mem_rd_if.ack;
    assign rd_data        = mem_rd_if.data;

    axi3_mem_adapter axi3_mem_adapter_i (
        .clk       (clk),
        .srst      (srst),
        .mem_wr_if (mem_wr_if),
        .mem_rd_if (mem_rd_if),
        .axi3_if   (axi3_if)
    );

    axi3_ram axi3_ram_i (
        .clk       (clk),
        .srst      (srst),
        .init_done (init_done),
        .axi3_if   (axi3_if)
    );

endmodule : axi3_mem_sys

/* sim/axi3_mem_sys_tb.sv */
module axi3_mem_sys_tb;

    localparam int WAIT_LIMIT  = 200;
    localparam int RAND_ROUNDS = 300;
    // Mapped byte range starts at zero
    localparam logic [31:0] MAP_BYTES = 32'(axi3_pkg::RAM_WORDS * 8);

    logic                          clk;
    logic                          srst;
    logic                          init_done;
    logic                          wr_req;
    logic [axi3_pkg::ADDR_WID-1:0] wr_addr;
    logic [axi3_pkg::DATA_WID-1:0] wr_data;
    logic                          wr_rdy;
    logic                          wr_ack;
    logic                          rd_req;
    logic [axi3_pkg::ADDR_WID-1:0] rd_addr;
    logic                          rd_rdy;
    logic                          rd_ack;
    logic [axi3_pkg::DATA_WID-1:0] rd_data;

    // Reference memory where missing entries read as zero
    logic [axi3_pkg::DATA_WID-1:0] model [int unsigned];

    // Addresses read back after a clear sweep
    logic [31:0] probe_addrs [$];

    logic [31:0] rng_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;

    axi3_mem_sys axi3_mem_sys_i (
        .clk       (clk),
        .srst      (srst),
        .init_done (init_done),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .wr_ack    (wr_ack),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data)
    );

    always #20 clk = ~clk;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic bit is_mapped(input logic [31:0] addr);
        return addr < MAP_BYTES;
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        int unsigned idx;
        idx = addr >> axi3_pkg::BYTE_SEL_WID;
        if (!is_mapped(addr) || !model.exists(idx)) begin
            return '0;
        end
        return model[idx];
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [63:0] data);
        if (is_mapped(addr)) begin
            model[addr >> axi3_pkg::BYTE_SEL_WID] = data;
        end
    endfunction

    // About one in four addresses lands above the mapped range
    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'b00) begin
            return r | 32'h0000_0800;
        end
        return r & 32'h0000_07ff;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles (time %0t)",
                 what, WAIT_LIMIT, $time);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    // Holds reset for 16 cycles and waits out the clear sweep
    task automatic reset_and_clear();
        int cnt;
        srst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        expect_true(wr_rdy && rd_rdy && !wr_ack && !rd_ack && !init_done,
                    "request outputs not idle in reset");
        srst = 1'b0;
        model.delete();

        // One word cleared per cycle
        cnt = 0;
        while (!init_done && cnt < axi3_pkg::RAM_WORDS + WAIT_LIMIT) begin
            cnt++;
            @(negedge clk);
        end
        if (!init_done) begin
            report_timeout("init_done");
        end
        expect_true(cnt == axi3_pkg::RAM_WORDS,
                    $sformatf("init_done low for %0d cycles", cnt));
    endtask

    // Starts and ends on a falling edge and counts cycles to the ack in lat
    task automatic write_req(input logic [31:0] addr, input logic [63:0] data,
                             output int lat);
        int cnt;
        cnt = 0;
        while (!wr_rdy && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!wr_rdy) begin
            report_timeout("wr_rdy");
        end
        wr_req  = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_req = 1'b0;
        expect_true(!wr_rdy, "wr_rdy still high after acceptance");
        lat = 1;
        while (!wr_ack && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!wr_ack) begin
            report_timeout("wr_ack");
        end else begin
            @(negedge clk);
            expect_true(!wr_ack, "wr_ack longer than one cycle");
            expect_true(wr_rdy, "wr_rdy did not return after wr_ack");
        end
    endtask

    task automatic read_req(input logic [31:0] addr, output logic [63:0] data,
                            output int lat);
        int cnt;
        cnt = 0;
        while (!rd_rdy && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rd_rdy) begin
            report_timeout("rd_rdy");
        end
        rd_req  = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_req = 1'b0;
        expect_true(!rd_rdy, "rd_rdy still high after acceptance");
        lat = 1;
        while (!rd_ack && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        data = rd_data;
        if (!rd_ack) begin
            report_timeout("rd_ack");
        end else begin
            @(negedge clk);
            expect_true(!rd_ack, "rd_ack longer than one cycle");
            expect_true(rd_rdy, "rd_rdy did not return after rd_ack");
        end
    endtask

    task automatic check_cleared();
        logic [63:0] q;
        int          lat;
        foreach (probe_addrs[i]) begin
            read_req(probe_addrs[i], q, lat);
            expect_true(q == '0,
                        $sformatf("addr %h not cleared, read %h", probe_addrs[i], q));
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int          cnt;
        int          acks;
        int          lat_w;
        int          lat_r;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] d;
        logic [63:0] q;

        clk           = 1'b0;
        srst          = 1'b1;
        wr_req        = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_req        = 1'b0;
        rd_addr       = '0;
        rng_state     = 32'h8b322c3e;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_err_base = 0;

        reset_and_clear();
        repeat (16) begin
            probe_addrs.push_back(next_rand() & 32'h0000_07ff);
        end
        check_cleared();
        finish_test("clear");

        // Write then read with aliased low address bits
        for (int i = 0; i < 24; i++) begin
            a = next_rand() & 32'h0000_07ff;
            d = {next_rand(), next_rand()};
            write_req(a, d, lat_w);
            model_write(a, d);
            expect_true(lat_w <= 5, $sformatf("write latency %0d", lat_w));
            b = (a & ~32'h7) | (next_rand() & 32'h7);
            read_req(b, q, lat_r);
            expect_true(q == expected_word(b),
                        $sformatf("addr %h read %h, expected %h", b, q, expected_word(b)));
            expect_true(lat_r <= 8, $sformatf("read latency %0d", lat_r));
        end
        finish_test("write_read");

        // Request held high through the pending write
        a       = next_rand() & 32'h0000_07ff;
        d       = {next_rand(), next_rand()};
        wr_addr = a;
        wr_data = d;
        wr_req  = 1'b1;
        @(negedge clk);
        cnt = 0;
        while (!wr_ack && cnt < WAIT_LIMIT) begin
            expect_true(!wr_rdy, "wr_rdy high while write pending");
            @(negedge clk);
            cnt++;
        end
        if (!wr_ack) begin
            report_timeout("wr_ack with held request");
        end
        wr_req = 1'b0;
        model_write(a, d);
        acks = 0;
        repeat (10) begin
            @(negedge clk);
            if (wr_ack) begin
                acks++;
            end
        end
        expect_true(acks == 0, $sformatf("%0d extra wr_ack pulses", acks));
        expect_true(wr_rdy, "wr_rdy low after handshake");
        finish_test("handshake");

        // Unmapped write is dropped and unmapped read returns zero
        b = next_rand() & 32'h0000_07f8;
        d = {next_rand(), next_rand()} | 64'h1;
        write_req(b, d, lat_w);
        model_write(b, d);
        read_req(b, q, lat_r);
        expect_true(q == d, $sformatf("addr %h read %h, expected %h", b, q, d));
        a = b | (next_rand() & ~32'h0000_07ff) | 32'h0000_0800;
        write_req(a, ~d, lat_w);
        expect_true(lat_w >= axi3_pkg::WR_TIMEOUT && lat_w <= axi3_pkg::WR_TIMEOUT + 4,
                    $sformatf("unmapped write latency %0d", lat_w));
        read_req(b, q, lat_r);
        expect_true(q == expected_word(b), $sformatf("unmapped write to %h reached RAM", a));
        read_req(a, q, lat_r);
        expect_true(q == '0, $sformatf("unmapped read returned %h", q));
        expect_true(lat_r >= axi3_pkg::RD_TIMEOUT && lat_r <= axi3_pkg::RD_TIMEOUT + 4,
                    $sformatf("unmapped read latency %0d", lat_r));
        finish_test("timeout");

        // Both channels at once while the read avoids the word being written
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            a = random_addr();
            d = {next_rand(), next_rand()};
            b = random_addr();
            if (is_mapped(a) && is_mapped(b) && (a >> 3) == (b >> 3)) begin
                b = b ^ 32'h8;
            end
            fork
                write_req(a, d, lat_w);
                read_req(b, q, lat_r);
            join
            expect_true(q == expected_word(b),
                        $sformatf("addr %h read %h, expected %h", b, q, expected_word(b)));
            model_write(a, d);
        end
        finish_test("random");

        // Second sweep over words that now hold nonzero data
        probe_addrs.delete();
        foreach (model[idx]) begin
            if (model[idx] != '0 && probe_addrs.size() < 16) begin
                probe_addrs.push_back(idx << axi3_pkg::BYTE_SEL_WID);
            end
        end
        reset_and_clear();
        check_cleared();
        finish_test("reset_clear");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : axi3_mem_sys_tb

/* axi3_mem_sys.f */
verilog/axi3_pkg.sv
verilog/mem_wr_intf.sv
verilog/mem_rd_intf.sv
verilog/axi3_intf.sv
verilog/axi3_mem_adapter.sv
verilog/axi3_ram.sv
verilog/axi3_mem_sys.sv
sim/axi3_mem_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module axi3_mem_sys_tb \
    -f axi3_mem_sys.f -o axi3_mem_sys_sim \
    && ./obj_dir/axi3_mem_sys_sim | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q "Simulation PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
